/* vlog.f */
hdl/pack_buf_pkg.sv
hdl/byte_packer.sv
hdl/fifo_based_on_regs.sv
hdl/packet_release.sv
hdl/pack_buf_top.sv
dv/pack_buf_properties.sv
dv/pack_buf_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the pack_buf testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module pack_buf_tb \
    -Mdir obj_dir -o simv \
    -f vlog.f

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    exit 1
fi
exit 0

/* dv/pack_buf_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module pack_buf_tb;

    localparam int fifo_depth      = 8;
    localparam int almost_full_th  = 6;
    localparam int almost_empty_th = 2;
    localparam int wait_limit      = 400;

    logic                        clk;
    logic                        rst_n;
    logic                        byte_valid;
    pack_buf_pkg::byte_t         byte_data;
    logic                        byte_last;
    logic                        byte_ready;
    logic                        out_valid;
    pack_buf_pkg::pack_word_t    out_word;
    logic                        out_ready;
    logic                        buf_almost_full;
    logic [$clog2(fifo_depth):0] buf_cnt;

    pack_buf_pkg::pack_word_t exp_q[$];  // reference model of the buffer contents
    pack_buf_pkg::pack_word_t exp_head;
    logic                     exp_avail;
    int                       pending_last;
    pack_buf_pkg::word_t      acc;
    int                       acc_idx;
    logic [15:0]              lfsr_main;
    logic [15:0]              lfsr_rdy;
    logic                     stall_out;  // forces out_ready low
    int                       stall_left;
    logic                     saw_block;
    logic                     saw_full;

    pack_buf_top #(
        .fifo_depth      (fifo_depth),
        .almost_full_th  (almost_full_th),
        .almost_empty_th (almost_empty_th)
    ) UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .byte_valid      (byte_valid),
        .byte_data       (byte_data),
        .byte_last       (byte_last),
        .byte_ready      (byte_ready),
        .out_valid       (out_valid),
        .out_word        (out_word),
        .out_ready       (out_ready),
        .buf_almost_full (buf_almost_full),
        .buf_cnt         (buf_cnt)
    );

    always #5 clk = ~clk;

    // taps 16 14 13 11
    function automatic logic lfsr_step(inout logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        s  = {s[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(int n, inout logic [15:0] s);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            v = (v << 1) | int'(lfsr_step(s));
        end
        return v;
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // reference model, updated from the pre-edge values
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (out_valid && out_ready && exp_q.size() > 0)
            begin
                if (exp_q[0].last)
                begin
                    pending_last <= pending_last - 1;
                end
                void'(exp_q.pop_front());
            end
            if (byte_valid && byte_ready)
            begin
                acc[acc_idx*8 +: 8] = byte_data;
                if (byte_last || acc_idx == 3)
                begin
                    exp_q.push_back('{data: acc, cnt: 2'(acc_idx), last: byte_last});
                    if (byte_last)
                    begin
                        pending_last <= pending_last + 1 - ((out_valid && out_ready
                            && exp_head.last) ? 1 : 0);
                    end
                    acc     = '0;
                    acc_idx = 0;
                end
                else
                begin
                    acc_idx = acc_idx + 1;
                end
            end
            exp_avail <= (exp_q.size() > 0);
            exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
        end
    end

    // out_ready pattern with random bubbles and long stalls
    always @(posedge clk)
    begin
        if (stall_out)
        begin
            out_ready <= 1'b0;
        end
        else if (stall_left > 0)
        begin
            stall_left <= stall_left - 1;
            out_ready  <= 1'b0;
        end
        else if (rand_bits(5, lfsr_rdy) == 0)
        begin
            stall_left <= 10 + rand_bits(3, lfsr_rdy);
            out_ready  <= 1'b0;
        end
        else
        begin
            out_ready <= (rand_bits(2, lfsr_rdy) != 0);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> exp_avail)
    else report_fail("output word arrived while the reference queue was empty");

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && exp_avail |-> out_word == exp_head)
    else
    begin
        $display("FAIL out_word got %h expected %h", $sampled(out_word), $sampled(exp_head));
        report_fail("output word mismatch");
    end

    // words are held back until a packet end or enough fill
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (buf_cnt > almost_empty_th) || (pending_last != 0))
    else report_fail("out_valid raised before the release condition held");

    assert property (@(posedge clk) $rose(rst_n) |-> !out_valid && byte_ready && buf_cnt == 0)
    else
    begin
        $display("FAIL out_valid %h byte_ready %h buf_cnt %h expected 0 1 0",
            $sampled(out_valid), $sampled(byte_ready), $sampled(buf_cnt));
        report_fail("wrong output state after reset release");
    end

    task automatic send_byte(input pack_buf_pkg::byte_t b, input logic last);
        int n;
        byte_valid <= 1'b1;
        byte_data  <= b;
        byte_last  <= last;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
            if (!byte_ready)
            begin
                saw_block = 1'b1;
                if (buf_cnt == fifo_depth)
                begin
                    saw_full = 1'b1;
                end
                stall_out <= 1'b0; // let the output drain
            end
            if (n > wait_limit)
            begin
                report_fail("timeout waiting for byte_ready");
            end
        end
        while (!byte_ready);
    endtask

    task automatic send_packet(input int len, input logic gaps);
        int gap;
        for (int i = 0; i < len; i++)
        begin
            send_byte(8'(rand_bits(8, lfsr_main)), i == len - 1);
            if (gaps && rand_bits(2, lfsr_main) == 0)
            begin
                gap = 1 + rand_bits(2, lfsr_main);
                byte_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        byte_valid <= 1'b0;
    endtask

    initial
    begin
        int n;
        clk          = 1'b0;
        rst_n        = 1'b0;
        byte_valid   = 1'b0;
        byte_data    = '0;
        byte_last    = 1'b0;
        out_ready    = 1'b0;
        lfsr_main    = 16'd43044;
        lfsr_rdy     = 16'd43044;
        stall_out    = 1'b0;
        stall_left   = 0;
        saw_block    = 1'b0;
        saw_full     = 1'b0;
        pending_last = 0;
        acc          = '0;
        acc_idx      = 0;
        exp_avail    = 1'b0;
        exp_head     = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int p = 0; p < 40; p++)
        begin
            send_packet(1 + rand_bits(4, lfsr_main) % 9, 1'b1);
        end

        // fill the FIFO against a blocked output
        stall_out <= 1'b1;
        send_packet(48, 1'b0);
        if (!saw_block || !saw_full)
        begin
            report_fail("FIFO never filled up to block a completing byte");
        end

        for (int p = 0; p < 30; p++)
        begin
            send_packet(1 + rand_bits(4, lfsr_main) % 9, 1'b1);
        end

        // exp_avail lags the queue by one edge, so the last push is seen
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
            if (n > wait_limit)
            begin
                report_fail("timeout waiting for the buffer to drain");
            end
        end
        while (exp_avail);
        repeat (3) @(posedge clk);

        if (exp_q.size() != 0 || out_valid)
        begin
            report_fail("words left over at the end of the run");
        end
        else
        begin
            $display("*** PASSED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/pack_buf_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module pack_buf_properties #(
    parameter int fifo_depth     = 8,
    parameter int almost_full_th = 6
)(
    input wire                           clk,
    input wire                           rst_n,
    input wire                           out_valid,
    input wire                           out_ready,
    input wire pack_buf_pkg::pack_word_t out_word,
    input wire                           buf_almost_full,
    input wire [$clog2(fifo_depth):0]    buf_cnt
);

    // offered word holds until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_word))
    else $error("out_valid or out_word changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n)
        buf_almost_full == (buf_cnt >= almost_full_th))
    else $error("buf_almost_full disagrees with buf_cnt");

    assert property (@(posedge clk) disable iff (!rst_n)
        buf_cnt <= fifo_depth)
    else $error("buf_cnt above the FIFO depth");

    // nothing to offer when the FIFO is empty
    assert property (@(posedge clk) disable iff (!rst_n)
        buf_cnt == 0 |-> !out_valid)
    else $error("out_valid with an empty FIFO");

endmodule

bind pack_buf_top pack_buf_properties #(
    .fifo_depth     (fifo_depth),
    .almost_full_th (almost_full_th)
) u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_word        (out_word),
    .buf_almost_full (buf_almost_full),
    .buf_cnt         (buf_cnt)
);

`default_nettype wire

/* hdl/pack_buf_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pack_buf_top #(
    parameter int fifo_depth      = 8,
    parameter int almost_full_th  = 6,
    parameter int almost_empty_th = 2
)(
    input  wire                             clk,
    input  wire                             rst_n,

    input  wire                             byte_valid,
    input  wire pack_buf_pkg::byte_t        byte_data,
    input  wire                             byte_last,
    output logic                            byte_ready,

    output logic                            out_valid,
    output pack_buf_pkg::pack_word_t        out_word,
    input  wire                             out_ready,

    output logic                            buf_almost_full,
    output logic [$clog2(fifo_depth):0]     buf_cnt
);

    pack_buf_pkg::pack_word_t fifo_din;
    pack_buf_pkg::pack_word_t fifo_dout;
    logic                     fifo_wen;
    logic                     fifo_full_n;
    logic                     fifo_ren;
    logic                     fifo_empty_n;
    logic                     fifo_almost_empty;

    byte_packer u_packer (
        .clk         (clk),
        .rst_n       (rst_n),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_last   (byte_last),
        .byte_ready  (byte_ready),
        .fifo_full_n (fifo_full_n),
        .fifo_wen    (fifo_wen),
        .fifo_din    (fifo_din)
    );

    fifo_based_on_regs #(
        .fifo_depth      (fifo_depth),
        .fifo_data_width (pack_buf_pkg::PACK_WORD_W),
        .almost_full_th  (almost_full_th),
        .almost_empty_th (almost_empty_th)
    ) u_fifo (
        .clk                 (clk),
        .rst_n               (rst_n),
        .fifo_wen            (fifo_wen),
        .fifo_din            (fifo_din),
        .fifo_full           (),
        .fifo_full_n         (fifo_full_n),
        .fifo_almost_full    (buf_almost_full),
        .fifo_almost_full_n  (),
        .fifo_ren            (fifo_ren),
        .fifo_dout           (fifo_dout),
        .fifo_empty          (),
        .fifo_empty_n        (fifo_empty_n),
        .fifo_almost_empty   (fifo_almost_empty),
        .fifo_almost_empty_n (),
        .data_cnt            (buf_cnt)
    );

    packet_release #(
        .fifo_depth (fifo_depth)
    ) u_release (
        .clk               (clk),
        .rst_n             (rst_n),
        .fifo_dout         (fifo_dout),
        .fifo_empty_n      (fifo_empty_n),
        .fifo_almost_empty (fifo_almost_empty),
        .fifo_ren          (fifo_ren),
        .wr_strobe         (fifo_wen),
        .wr_last           (fifo_din.last),
        .out_valid         (out_valid),
        .out_word          (out_word),
        .out_ready         (out_ready)
    );

endmodule

`default_nettype wire

/* hdl/packet_release.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_release #(
    parameter int fifo_depth = 8
)(
    input  wire                             clk,
    input  wire                             rst_n,

    // FIFO read side
    input  wire pack_buf_pkg::pack_word_t   fifo_dout,
    input  wire                             fifo_empty_n,
    input  wire                             fifo_almost_empty,
    output logic                            fifo_ren,

    // word entering the FIFO
    input  wire                             wr_strobe,
    input  wire                             wr_last,

    // word stream out
    output logic                            out_valid,
    output pack_buf_pkg::pack_word_t        out_word,
    input  wire                             out_ready
);

    localparam int last_cnt_w = $clog2(fifo_depth) + 1;

    typedef logic [last_cnt_w-1:0] last_cnt_t;

    last_cnt_t last_cnt_q;   // last-flagged words inside the FIFO
    logic      last_in;
    logic      last_out;
    logic      release_ok;
    logic      held_q;       // an offered word is waiting for out_ready

    assign last_in  = wr_strobe & wr_last;
    assign last_out = fifo_ren & fifo_dout.last;

    // a packet end inside, or enough words to stream
    assign release_ok = (last_cnt_q != '0) | ~fifo_almost_empty;

    assign out_valid = fifo_empty_n & (release_ok | held_q);
    assign out_word  = fifo_dout;
    assign fifo_ren  = out_valid & out_ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            last_cnt_q <= '0;
        end
        else if (last_in && !last_out)
        begin
            last_cnt_q <= last_cnt_q + last_cnt_t'(1);
        end
        else if (last_out && !last_in)
        begin
            last_cnt_q <= last_cnt_q - last_cnt_t'(1);
        end
    end

    // keeps out_valid up once offered
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            held_q <= 1'b0;
        end
        else if (fifo_ren)
        begin
            held_q <= 1'b0;
        end
        else if (out_valid)
        begin
            held_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/fifo_based_on_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module fifo_based_on_regs #(
    parameter int fifo_depth      = 8,  // power of two, 4 or more
    parameter int fifo_data_width = 32,
    parameter int almost_full_th  = 6,  // 1 .. fifo_depth-1
    parameter int almost_empty_th = 2   // 1 .. fifo_depth-1
)(
    input  wire                         clk,
    input  wire                         rst_n,

    // FIFO WRITE
    input  wire                         fifo_wen,
    input  wire [fifo_data_width-1:0]   fifo_din,
    output logic                        fifo_full,
    output logic                        fifo_full_n,
    output logic                        fifo_almost_full,
    output logic                        fifo_almost_full_n,

    // FIFO READ, first word falls through
    input  wire                         fifo_ren,
    output logic [fifo_data_width-1:0]  fifo_dout,
    output logic                        fifo_empty,
    output logic                        fifo_empty_n,
    output logic                        fifo_almost_empty,
    output logic                        fifo_almost_empty_n,

    // fill level
    output logic [$clog2(fifo_depth):0] data_cnt
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = ptr_w + 1;

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [cnt_w-1:0] cnt_t;

    // count values at which a flag changes on the next step
    localparam cnt_t cnt_one  = cnt_t'(1);
    localparam cnt_t cnt_top  = cnt_t'(fifo_depth - 1);
    localparam cnt_t af_below = cnt_t'(almost_full_th - 1);
    localparam cnt_t af_above = cnt_t'(almost_full_th + 1);
    localparam cnt_t ae_below = cnt_t'(almost_empty_th - 1);
    localparam cnt_t ae_above = cnt_t'(almost_empty_th + 1);

    logic                       wr_ok;
    logic                       rd_ok;
    logic                       grow;
    logic                       shrink;
    cnt_t                       cnt_q;
    logic                       empty_q;
    logic                       full_q;
    logic                       almost_empty_q;
    logic                       almost_full_q;
    ptr_t                       rptr_nxt_q;   // kept one ahead for the fall-through load
    logic [fifo_depth-1:0]      wptr_oh_q;
    logic [fifo_data_width-1:0] mem [fifo_depth];
    logic [fifo_data_width-1:0] dout_q;

    // accepted transfers only
    assign wr_ok  = fifo_wen & ~full_q;
    assign rd_ok  = fifo_ren & ~empty_q;
    assign grow   = wr_ok & ~rd_ok;
    assign shrink = rd_ok & ~wr_ok;

    assign fifo_full           = full_q;
    assign fifo_full_n         = ~full_q;
    assign fifo_almost_full    = almost_full_q;
    assign fifo_almost_full_n  = ~almost_full_q;
    assign fifo_empty          = empty_q;
    assign fifo_empty_n        = ~empty_q;
    assign fifo_almost_empty   = almost_empty_q;
    assign fifo_almost_empty_n = ~almost_empty_q;
    assign data_cnt            = cnt_q;
    assign fifo_dout           = dout_q;

    // flags are computed from the count before the step
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt_q          <= '0;
            empty_q        <= 1'b1;
            full_q         <= 1'b0;
            almost_empty_q <= 1'b1;
            almost_full_q  <= 1'b0;
        end
        else if (grow)
        begin
            cnt_q          <= cnt_q + cnt_one;
            empty_q        <= 1'b0;
            full_q         <= (cnt_q == cnt_top);
            almost_empty_q <= (cnt_q <= ae_below);
            almost_full_q  <= (cnt_q >= af_below);
        end
        else if (shrink)
        begin
            cnt_q          <= cnt_q - cnt_one;
            empty_q        <= (cnt_q == cnt_one);
            full_q         <= 1'b0;
            almost_empty_q <= (cnt_q <= ae_above);
            almost_full_q  <= (cnt_q >= af_above);
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rptr_nxt_q <= ptr_t'(1);
        end
        else if (rd_ok)
        begin
            rptr_nxt_q <= rptr_nxt_q + ptr_t'(1);
        end
    end

    // one-hot write pointer, rotates left
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wptr_oh_q <= fifo_depth'(1);
        end
        else if (wr_ok)
        begin
            wptr_oh_q <= {wptr_oh_q[fifo_depth-2:0], wptr_oh_q[fifo_depth-1]};
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < fifo_depth; i++)
        begin
            if (wr_ok && wptr_oh_q[i])
            begin
                mem[i] <= fifo_din;
            end
        end
    end

    // head register: reload when empty or on a read
    // a read of the only word with a write in the same cycle takes din
    always_ff @(posedge clk)
    begin
        if (empty_q || fifo_ren)
        begin
            if (!empty_q && !(wr_ok && cnt_q == cnt_one))
            begin
                dout_q <= mem[rptr_nxt_q];
            end
            else
            begin
                dout_q <= fifo_din;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/byte_packer.sv */
`timescale 1ns/1ns
`default_nettype none

module byte_packer (
    input  wire                             clk,
    input  wire                             rst_n,

    // byte stream in
    input  wire                             byte_valid,
    input  wire pack_buf_pkg::byte_t        byte_data,
    input  wire                             byte_last,
    output logic                            byte_ready,

    // FIFO write side
    input  wire                             fifo_full_n,
    output logic                            fifo_wen,
    output pack_buf_pkg::pack_word_t        fifo_din
);

    pack_buf_pkg::word_t     hold_q;  // lanes below idx_q hold bytes
    pack_buf_pkg::byte_cnt_t idx_q;   // lane of the next byte
    logic                    completing;
    logic                    accept;

    // the fourth byte or a last byte closes the word
    assign completing = byte_last | (idx_q == 2'd3);

    // only a closing byte needs room in the FIFO
    assign byte_ready = ~completing | fifo_full_n;
    assign accept     = byte_valid & byte_ready;
    assign fifo_wen   = accept & completing;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            idx_q <= '0;
        end
        else if (fifo_wen)
        begin
            idx_q <= '0; // start a fresh word
        end
        else if (accept)
        begin
            idx_q <= idx_q + 2'd1;
        end
    end

    // holding lanes, only written below lane 3
    always_ff @(posedge clk)
    begin
        if (accept && !completing)
        begin
            hold_q[{idx_q, 3'b000} +: 8] <= byte_data;
        end
    end

    // word assembly: held lanes, the closing byte at idx_q, zeros above
    always_comb
    begin
        fifo_din.data = '0;
        for (int i = 0; i < pack_buf_pkg::word_bytes; i++)
        begin
            if (i < int'(idx_q))
            begin
                fifo_din.data[i*8 +: 8] = hold_q[i*8 +: 8];
            end
            else if (i == int'(idx_q))
            begin
                fifo_din.data[i*8 +: 8] = byte_data;
            end
        end
        fifo_din.cnt  = idx_q;     // lane index doubles as count minus one
        fifo_din.last = byte_last;
    end

endmodule

`default_nettype wire

/* hdl/pack_buf_pkg.sv */
`default_nettype none

package pack_buf_pkg;

    // stream and word widths
    typedef logic [7:0]  byte_t;     // one stream byte
    typedef logic [31:0] word_t;     // lane 0 sits in bits 7:0
    typedef logic [1:0]  byte_cnt_t; // valid bytes minus one

    // lanes per packed word
    localparam int word_bytes = 4;

    // one FIFO entry, also the output word of the buffer
    typedef struct packed {
        word_t     data;
        byte_cnt_t cnt;  // 0 means a single byte
        logic      last; // closes a packet
    } pack_word_t;

    // FIFO data width at the top
    localparam int PACK_WORD_W = $bits(pack_word_t);

endpackage

`default_nettype wire
